//--- all.f
verilog/conv_pkg.sv
verilog/sp_ram.sv
verilog/buffer_bank.sv
verilog/conv_ctrl.sv
verilog/mac9.sv
verilog/out_stage.sv
verilog/conv1x1_top.sv
tests/tb_conv1x1.sv

//--- run.sh
#!/bin/sh
# build the conv1x1 testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_conv1x1 -f all.f \
	-o sim_conv1x1 > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_conv1x1 > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation failed"
	exit 1
fi
grep -q "PASS: all tests" sim.log
echo "simulation passed"

//--- tests/tb_conv1x1.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv1x1 import conv_pkg::*; ();

	// kernels x groups x pixels of every run
	localparam int work_units = 1*1*4 + 2*3*9 + 3*1*4 + 2*1*4 + 3*2*16;
	localparam int watchdog_cycles = work_units * 20 + 2000;

	logic clk;
	logic rstn;
	logic start;
	logic [31:0] codebook;
	logic busy;
	logic finish;
	logic host_en;
	logic host_we;
	mem_sel_t host_sel;
	logic [addr_w-1:0] host_addr;
	logic [code_w-1:0] host_wdata;
	logic [code_w-1:0] host_rdata;

	// shadow copy of what the host loaded
	logic [data_w-1:0] m_bias [bias_depth];
	logic [code_w-1:0] m_wt [wt_depth];
	logic [data_w-1:0] m_in [in_depth];
	int m_rows;
	int m_ch;
	int m_k;
	int errors = 0;
	int fin_count = 0;

	conv1x1_top DUT (
		.clk(clk), .rstn(rstn), .start(start), .codebook(codebook),
		.busy(busy), .finish(finish),
		.host_en(host_en), .host_we(host_we), .host_sel(host_sel),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(negedge clk) begin
		if (finish === 1'b1) begin
			fin_count++;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog: run did not end within %0d cycles", watchdog_cycles);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// all host tasks start and end 1 ns after a rising edge
	task automatic host_write(input mem_sel_t sel, input int addr, input logic [code_w-1:0] data);
		host_en = 1'b1;
		host_we = 1'b1;
		host_sel = sel;
		host_addr = addr_w'(addr);
		host_wdata = data;
		@(posedge clk);
		#1;
		host_en = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic host_read(input mem_sel_t sel, input int addr, output logic [code_w-1:0] data);
		host_en = 1'b1;
		host_we = 1'b0;
		host_sel = sel;
		host_addr = addr_w'(addr);
		@(posedge clk);
		#1;
		host_en = 1'b0;
		data = host_rdata;
	endtask

	task automatic set_params(input int rows, input int ch, input int kernels);
		m_rows = rows;
		m_ch = ch;
		m_k = kernels;
		host_write(sel_param, 0, code_w'(rows));
		host_write(sel_param, 1, code_w'(ch));
		host_write(sel_param, 2, code_w'(kernels));
	endtask

	task automatic write_bias(input int k, input logic [data_w-1:0] val);
		m_bias[k] = val;
		host_write(sel_bias, k, code_w'(val));
	endtask

	task automatic add_weight(input int addr, input logic [code_w-1:0] val);
		m_wt[addr] = val;
		host_write(sel_weight, addr, val);
	endtask

	task automatic place_input(input int addr, input logic [data_w-1:0] val);
		m_in[addr] = val;
		host_write(sel_input, addr, code_w'(val));
	endtask

	function automatic logic [data_w-1:0] fill_word(input int addr, input int salt);
		return data_w'(addr * 40503 + (addr >> 5) * 977 + salt * 131 + 29);
	endfunction

	function automatic logic [code_w-1:0] fill_code(input int addr, input int salt);
		return code_w'(addr * 93187 + salt * 3571 + 5);
	endfunction

	// relu, saturate when bits 15..12 are set, else keep bits 12..5
	function automatic logic [data_w-1:0] requantize(input logic [data_w-1:0] v);
		if (v[15]) begin
			return 16'd0;
		end
		if (v[15:12] != 4'd0) begin
			return 16'd127;
		end
		return {8'd0, v[12:5]};
	endfunction

	function automatic logic [data_w-1:0] expected_out(input int k, input int p,
			input logic [31:0] cb);
		int pix;
		int groups;
		int c;
		int code;
		logic signed [7:0] wv;
		logic signed [7:0] xv;
		logic [data_w-1:0] gsum;
		logic [data_w-1:0] acc;
		pix = m_rows * m_rows;
		groups = (m_ch + lanes - 1) / lanes;
		acc = '0;
		for (int g = 0; g < groups; g++) begin
			gsum = '0;
			for (int i = 0; i < lanes; i++) begin
				c = g * lanes + i;
				if (c < m_ch) begin
					code = int'(m_wt[k * groups + g][2*i +: 2]);
					wv = cb[8*code +: 8];
					xv = m_in[c * pix + p][7:0];
					gsum = gsum + data_w'(int'(xv) * int'(wv));
				end
			end
			// first group starts from the bias
			acc = (g == 0) ? m_bias[k] + gsum : acc + gsum;
		end
		return requantize(acc);
	endfunction

	task automatic verify_outputs(input logic [31:0] cb, input string tag);
		logic [code_w-1:0] rd;
		int pix;
		pix = m_rows * m_rows;
		for (int k = 0; k < m_k; k++) begin
			for (int p = 0; p < pix; p++) begin
				host_read(sel_output, k * pix + p, rd);
				check_word(rd[data_w-1:0], expected_out(k, p, cb),
					$sformatf("%s output k%0d p%0d", tag, k, p));
			end
		end
	endtask

	// disturb drives a new codebook and extra starts while busy
	task automatic run_conv(input logic [31:0] cb, input bit disturb);
		int limit;
		int cycles;
		int fin_before;
		limit = m_k * ((m_ch + lanes - 1) / lanes) * m_rows * m_rows * 20 + 200;
		fin_before = fin_count;
		cycles = 0;
		codebook = cb;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_flag(busy, 1'b1, "busy after start");
		if (disturb) begin
			for (int i = 0; i < 3; i++) begin
				codebook = ~cb ^ 32'(i * 77);
				start = 1'b1;
				@(posedge clk);
				#1;
				start = 1'b0;
				@(posedge clk);
				#1;
			end
		end
		while (finish !== 1'b1) begin
			if (cycles >= limit) begin
				$display("run_conv: no finish pulse within %0d cycles", limit);
				$display("FAIL: see errors above");
				$fatal(1);
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		check_flag(busy, 1'b1, "busy while finish is high");
		@(posedge clk);
		#1;
		check_flag(finish, 1'b0, "finish lasts one cycle");
		check_flag(busy, 1'b0, "busy falls with finish");
		check_flag(fin_count == fin_before + 1, 1'b1, "one finish pulse per run");
	endtask

	task automatic reset_and_host_access();
		logic [code_w-1:0] rd;
		check_flag(busy, 1'b0, "busy after reset");
		check_flag(finish, 1'b0, "finish after reset");
		host_write(sel_param, 3, 18'h0_5a5a);
		host_write(sel_bias, 15, 18'h0_8001);
		host_write(sel_weight, 63, 18'h2_c3f1);
		host_write(sel_input, 1023, 18'h0_7e81);
		host_write(sel_output, 511, 18'h0_beef);
		host_read(sel_param, 3, rd);
		check_word(rd[data_w-1:0], 16'h5a5a, "param readback");
		host_read(sel_weight, 63, rd);
		check_word(rd[data_w-1:0], 16'hc3f1, "weight readback low bits");
		check_flag(rd[17], 1'b1, "weight readback bit 17");
		check_flag(rd[16], 1'b0, "weight readback bit 16");
		host_read(sel_bias, 15, rd);
		check_word(rd[data_w-1:0], 16'h8001, "bias readback");
		host_read(sel_output, 511, rd);
		check_word(rd[data_w-1:0], 16'hbeef, "output readback");
		host_read(sel_input, 1023, rd);
		check_word(rd[data_w-1:0], 16'h7e81, "input readback");
	endtask

	task automatic single_group_conv();
		set_params(2, 3, 1);
		write_bias(0, 16'd200);
		add_weight(0, fill_code(0, 1));
		for (int a = 0; a < 12; a++) begin
			place_input(a, fill_word(a, 1));
		end
		run_conv(32'h05fd_0301, 1'b0);
		verify_outputs(32'h05fd_0301, "single group");
	endtask

	// codebook extremes push group sums past 16 bits
	task automatic multi_group_wrap();
		set_params(3, 20, 2);
		for (int k = 0; k < 2; k++) begin
			write_bias(k, fill_word(k, 7));
		end
		for (int w = 0; w < 6; w++) begin
			add_weight(w, fill_code(w, 2));
		end
		for (int a = 0; a < 180; a++) begin
			place_input(a, fill_word(a, 3));
		end
		run_conv(32'h807f_817e, 1'b0);
		verify_outputs(32'h807f_817e, "multi group");
	endtask

	task automatic requantize_cases();
		logic [code_w-1:0] rd;
		set_params(2, 2, 3);
		// small sums, so the bias decides the range
		write_bias(0, 16'hfc18);
		write_bias(1, 16'd5000);
		write_bias(2, 16'd1000);
		for (int k = 0; k < 3; k++) begin
			add_weight(k, fill_code(k, 4));
		end
		for (int a = 0; a < 8; a++) begin
			place_input(a, data_w'((a * 7) % 21 - 10));
		end
		run_conv(32'h02ff_0102, 1'b0);
		verify_outputs(32'h02ff_0102, "requantize");
		for (int p = 0; p < 4; p++) begin
			host_read(sel_output, p, rd);
			check_word(rd[data_w-1:0], 16'd0, "negative result clamps to zero");
			host_read(sel_output, 4 + p, rd);
			check_word(rd[data_w-1:0], 16'd127, "large result saturates");
		end
	endtask

	task automatic inputs_ignored_while_busy();
		int fin_before;
		set_params(2, 5, 2);
		write_bias(0, fill_word(0, 5));
		write_bias(1, fill_word(1, 5));
		add_weight(0, fill_code(0, 5));
		add_weight(1, fill_code(1, 5));
		for (int a = 0; a < 20; a++) begin
			place_input(a, fill_word(a, 5));
		end
		run_conv(32'h11e5_3ac7, 1'b1);
		fin_before = fin_count;
		repeat (20) @(posedge clk);
		#1;
		check_flag(fin_count == fin_before, 1'b1, "no extra finish after run");
		check_flag(busy, 1'b0, "engine stays idle");
		verify_outputs(32'h11e5_3ac7, "busy inputs");
	endtask

	task automatic random_maps();
		logic [31:0] cb;
		set_params(4, 11, 3);
		for (int k = 0; k < 3; k++) begin
			write_bias(k, data_w'($urandom));
		end
		for (int w = 0; w < 6; w++) begin
			add_weight(w, code_w'($urandom));
		end
		for (int a = 0; a < 176; a++) begin
			place_input(a, data_w'($urandom));
		end
		cb = $urandom;
		run_conv(cb, 1'b0);
		verify_outputs(cb, "random");
	endtask

	initial begin
		rstn = 1'b0;
		start = 1'b0;
		codebook = '0;
		host_en = 1'b0;
		host_we = 1'b0;
		host_sel = sel_param;
		host_addr = '0;
		host_wdata = '0;
		void'($urandom(68971));
		repeat (5) @(posedge clk);
		#1;
		rstn = 1'b1;
		reset_and_host_access();
		single_group_conv();
		multi_group_wrap();
		requantize_cases();
		inputs_ignored_while_busy();
		random_maps();
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/conv1x1_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv1x1_top import conv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic start,
	input logic [31:0] codebook,
	output logic busy,
	output logic finish,
	input logic host_en,
	input logic host_we,
	input mem_sel_t host_sel,
	input logic [addr_w-1:0] host_addr,
	input logic [code_w-1:0] host_wdata,
	output logic [code_w-1:0] host_rdata
);

	logic param_cs;
	logic [$clog2(param_depth)-1:0] param_addr;
	logic [data_w-1:0] param_rdata;
	logic bias_cs;
	logic [$clog2(bias_depth)-1:0] bias_addr;
	logic [data_w-1:0] bias_rdata;
	logic wt_cs;
	logic [$clog2(wt_depth)-1:0] wt_addr;
	logic [code_w-1:0] wt_rdata;
	logic in_cs;
	logic [$clog2(in_depth)-1:0] in_addr;
	logic [data_w-1:0] in_rdata;
	logic out_cs;
	logic out_we;
	logic [$clog2(out_depth)-1:0] out_addr;
	logic [data_w-1:0] out_rdata;
	logic [data_w-1:0] out_wdata;

	logic load_wt;
	logic load_lane;
	logic [3:0] lane_idx;
	logic [lanes-1:0] lane_valid;
	logic calc_go;
	logic sum_valid;
	logic [data_w-1:0] group_sum;
	acc_mode_t acc_mode;
	logic store;

	buffer_bank u_bank (
		.clk(clk), .busy(busy),
		.host_en(host_en), .host_we(host_we), .host_sel(host_sel),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
		.param_cs(param_cs), .param_addr(param_addr),
		.bias_cs(bias_cs), .bias_addr(bias_addr),
		.wt_cs(wt_cs), .wt_addr(wt_addr),
		.in_cs(in_cs), .in_addr(in_addr),
		.out_cs(out_cs), .out_we(out_we), .out_addr(out_addr), .out_wdata(out_wdata),
		.param_rdata(param_rdata), .bias_rdata(bias_rdata), .wt_rdata(wt_rdata),
		.in_rdata(in_rdata), .out_rdata(out_rdata)
	);

	conv_ctrl u_ctrl (
		.clk(clk), .rstn(rstn), .start(start),
		.param_cs(param_cs), .param_addr(param_addr), .param_rdata(param_rdata),
		.bias_cs(bias_cs), .bias_addr(bias_addr),
		.wt_cs(wt_cs), .wt_addr(wt_addr),
		.in_cs(in_cs), .in_addr(in_addr),
		.out_cs(out_cs), .out_we(out_we), .out_addr(out_addr),
		.busy(busy), .finish(finish),
		.load_wt(load_wt), .load_lane(load_lane), .lane_idx(lane_idx),
		.lane_valid(lane_valid), .calc_go(calc_go), .sum_valid(sum_valid),
		.acc_mode(acc_mode), .store(store)
	);

	// codebook is only taken from a start seen in idle
	mac9 u_mac (
		.clk(clk), .rstn(rstn), .start(start && !busy), .codebook(codebook),
		.wt_code(wt_rdata), .load_wt(load_wt),
		.in_byte(in_rdata[7:0]), .load_lane(load_lane), .lane_idx(lane_idx),
		.lane_valid(lane_valid), .calc_go(calc_go),
		.group_sum(group_sum), .sum_valid(sum_valid)
	);

	out_stage u_out (
		.clk(clk), .rstn(rstn), .store(store), .acc_mode(acc_mode),
		.bias_word(bias_rdata), .old_word(out_rdata), .group_sum(group_sum),
		.out_wdata(out_wdata)
	);

endmodule

`default_nettype wire

//--- verilog/out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module out_stage import conv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic store,
	input acc_mode_t acc_mode,
	input logic [data_w-1:0] bias_word,
	input logic [data_w-1:0] old_word,
	input logic [data_w-1:0] group_sum,
	output logic [data_w-1:0] out_wdata
);

	logic use_old;
	logic requant;
	logic [data_w-1:0] base;
	logic [data_w-1:0] run_val;
	logic [data_w-1:0] quant;

	always_comb begin
		use_old = (acc_mode == acc_mid) || (acc_mode == acc_last);
		requant = (acc_mode == acc_last) || (acc_mode == acc_single);
		base = use_old ? old_word : bias_word;
		run_val = base + group_sum;
		// relu, then clip anything above bits 12..5
		if (run_val[data_w-1]) begin
			quant = '0;
		end else if (|run_val[data_w-1 -: 4]) begin
			quant = data_w'(sat_max);
		end else begin
			quant = data_w'(run_val[shift_q +: 8]);
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out_wdata <= '0;
		end else if (store) begin
			out_wdata <= requant ? quant : run_val;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mac9.sv
`timescale 1ns/1ps
`default_nettype none

module mac9 import conv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic start,
	input logic [31:0] codebook,
	input logic [code_w-1:0] wt_code,
	input logic load_wt,
	input logic [7:0] in_byte,
	input logic load_lane,
	input logic [3:0] lane_idx,
	input logic [lanes-1:0] lane_valid,
	input logic calc_go,
	output logic [data_w-1:0] group_sum,
	output logic sum_valid
);

	logic [31:0] cb_q;
	logic signed [7:0] wt_q [lanes];
	logic signed [7:0] lane_q [lanes];
	logic signed [data_w-1:0] prod_q [lanes];
	logic signed [data_w-1:0] tree_sum;
	logic prod_v;

	always_ff @(posedge clk) begin
		if (start) begin
			cb_q <= codebook;
		end
	end

	// each 2-bit code picks one codebook byte
	always_ff @(posedge clk) begin
		if (load_wt) begin
			for (int i = 0; i < lanes; i++) begin
				wt_q[i] <= cb_q[{wt_code[2*i +: 2], 3'd0} +: 8];
			end
		end
	end

	// lanes past the group end are zeroed so they add nothing
	always_ff @(posedge clk) begin
		if (load_lane) begin
			for (int j = 0; j < lanes; j++) begin
				if (!lane_valid[j]) begin
					lane_q[j] <= '0;
				end else if (4'(j) == lane_idx) begin
					lane_q[j] <= in_byte;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (calc_go) begin
			for (int i = 0; i < lanes; i++) begin
				prod_q[i] <= lane_q[i] * wt_q[i];
			end
		end
	end

	always_comb begin
		tree_sum = '0;
		for (int i = 0; i < lanes; i++) begin
			tree_sum = tree_sum + prod_q[i];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_v) begin
			group_sum <= tree_sum;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			prod_v <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			prod_v <= calc_go;
			sum_valid <= prod_v;
		end
	end

endmodule

`default_nettype wire

//--- verilog/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl import conv_pkg::*; (
	input logic clk,
	input logic rstn,
	input logic start,
	output logic param_cs,
	output logic [$clog2(param_depth)-1:0] param_addr,
	input logic [data_w-1:0] param_rdata,
	output logic bias_cs,
	output logic [$clog2(bias_depth)-1:0] bias_addr,
	output logic wt_cs,
	output logic [$clog2(wt_depth)-1:0] wt_addr,
	output logic in_cs,
	output logic [$clog2(in_depth)-1:0] in_addr,
	output logic out_cs,
	output logic out_we,
	output logic [$clog2(out_depth)-1:0] out_addr,
	output logic busy,
	output logic finish,
	output logic load_wt,
	output logic load_lane,
	output logic [3:0] lane_idx,
	output logic [lanes-1:0] lane_valid,
	output logic calc_go,
	input logic sum_valid,
	output acc_mode_t acc_mode,
	output logic store
);

	ctrl_state_t state;
	ctrl_state_t state_nx;
	logic [3:0] step;
	logic step_done;

	logic [addr_w-1:0] rows;
	logic [addr_w-1:0] channels;
	logic [addr_w-1:0] kernels;
	logic [addr_w-1:0] pix;

	logic [addr_w-1:0] k_cnt;
	logic [addr_w-1:0] ch_base;
	logic [addr_w-1:0] pix_cnt;
	logic [$clog2(wt_depth)-1:0] wt_ptr;

	logic [addr_w-1:0] ch_left;
	logic [addr_w-1:0] in_ch;
	logic [addr_w-1:0] in_full;
	logic [addr_w-1:0] out_full;
	logic [3:0] n_lanes;
	logic last_pix;
	logic last_grp;
	logic last_k;

	assign pix = rows * rows;
	assign ch_left = channels - ch_base;
	// last group holds whatever channels remain
	assign last_grp = (ch_left <= addr_w'(lanes));
	assign n_lanes = last_grp ? ch_left[3:0] : 4'(lanes);
	assign last_pix = (pix_cnt == pix - 1'b1);
	assign last_k = (k_cnt == kernels - 1'b1);

	always_comb begin
		case (state)
			st_ld_param: step_done = (step == 4'd3);
			st_ld_bias, st_ld_wt, st_calc: step_done = (step == 4'd1);
			st_ld_in: step_done = (step == n_lanes);
			st_store: step_done = (step == 4'd2);
			default: step_done = 1'b1;
		endcase
	end

	always_comb begin
		state_nx = state;
		case (state)
			st_idle: begin
				if (start) begin
					state_nx = st_ld_param;
				end
			end
			st_ld_param: if (step_done) state_nx = st_ld_bias;
			st_ld_bias: if (step_done) state_nx = st_ld_wt;
			st_ld_wt: if (step_done) state_nx = st_ld_in;
			st_ld_in: if (step_done) state_nx = st_calc;
			st_calc: if (step_done) state_nx = st_store;
			st_store: begin
				// next pixel, next group, next kernel or done
				if (step_done) begin
					if (!last_pix) begin
						state_nx = st_ld_in;
					end else if (!last_grp) begin
						state_nx = st_ld_wt;
					end else if (!last_k) begin
						state_nx = st_ld_bias;
					end else begin
						state_nx = st_fin;
					end
				end
			end
			default: state_nx = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= st_idle;
			step <= '0;
		end else begin
			state <= state_nx;
			step <= step_done ? 4'd0 : step + 4'd1;
		end
	end

	// parameter words arrive one cycle after their address
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rows <= '0;
			channels <= '0;
			kernels <= '0;
		end else if (state == st_ld_param) begin
			case (step)
				4'd1: rows <= param_rdata[addr_w-1:0];
				4'd2: channels <= param_rdata[addr_w-1:0];
				4'd3: kernels <= param_rdata[addr_w-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			k_cnt <= '0;
			ch_base <= '0;
			pix_cnt <= '0;
		end else if (state == st_idle) begin
			k_cnt <= '0;
			ch_base <= '0;
			pix_cnt <= '0;
		end else if (state == st_store && step_done) begin
			if (!last_pix) begin
				pix_cnt <= pix_cnt + 1'b1;
			end else begin
				pix_cnt <= '0;
				if (!last_grp) begin
					ch_base <= ch_base + addr_w'(lanes);
				end else begin
					ch_base <= '0;
					k_cnt <= k_cnt + 1'b1;
				end
			end
		end
	end

	// weight words are stored in the order they are used
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wt_ptr <= '0;
		end else if (state == st_idle) begin
			wt_ptr <= '0;
		end else if (state == st_ld_wt && step_done) begin
			wt_ptr <= wt_ptr + 1'b1;
		end
	end

	assign param_addr = step[$clog2(param_depth)-1:0];
	assign bias_addr = k_cnt[$clog2(bias_depth)-1:0];
	assign wt_addr = wt_ptr;
	assign in_ch = ch_base + addr_w'(step);
	assign in_full = in_ch * pix + pix_cnt;
	assign in_addr = in_full[$clog2(in_depth)-1:0];
	assign out_full = k_cnt * pix + pix_cnt;
	assign out_addr = out_full[$clog2(out_depth)-1:0];

	assign busy = (state != st_idle);
	assign finish = (state == st_fin);
	assign param_cs = (state == st_ld_param);
	assign bias_cs = (state == st_ld_bias) && (step == 4'd0);
	assign wt_cs = (state == st_ld_wt) && (step == 4'd0);
	assign in_cs = (state == st_ld_in) && (step != n_lanes);
	// store reads the old word, waits, then writes it back
	assign out_cs = (state == st_store) && (step != 4'd1);
	assign out_we = (state == st_store) && (step == 4'd2);
	assign load_wt = (state == st_ld_wt) && (step == 4'd1);
	assign load_lane = (state == st_ld_in) && (step != 4'd0);
	assign lane_idx = step - 4'd1;
	assign calc_go = (state == st_calc) && (step == 4'd0);

	always_comb begin
		for (int j = 0; j < lanes; j++) begin
			lane_valid[j] = (4'(j) < n_lanes);
		end
	end

	always_comb begin
		if (ch_base == '0) begin
			acc_mode = last_grp ? acc_single : acc_first;
		end else begin
			acc_mode = last_grp ? acc_last : acc_mid;
		end
	end

	// old word is on the output buffer read port one cycle after the sum
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			store <= 1'b0;
		end else begin
			store <= sum_valid;
		end
	end

endmodule

`default_nettype wire

//--- verilog/buffer_bank.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_bank import conv_pkg::*; (
	input logic clk,
	input logic busy,
	input logic host_en,
	input logic host_we,
	input mem_sel_t host_sel,
	input logic [addr_w-1:0] host_addr,
	input logic [code_w-1:0] host_wdata,
	output logic [code_w-1:0] host_rdata,
	input logic param_cs,
	input logic [$clog2(param_depth)-1:0] param_addr,
	input logic bias_cs,
	input logic [$clog2(bias_depth)-1:0] bias_addr,
	input logic wt_cs,
	input logic [$clog2(wt_depth)-1:0] wt_addr,
	input logic in_cs,
	input logic [$clog2(in_depth)-1:0] in_addr,
	input logic out_cs,
	input logic out_we,
	input logic [$clog2(out_depth)-1:0] out_addr,
	input logic [data_w-1:0] out_wdata,
	output logic [data_w-1:0] param_rdata,
	output logic [data_w-1:0] bias_rdata,
	output logic [code_w-1:0] wt_rdata,
	output logic [data_w-1:0] in_rdata,
	output logic [data_w-1:0] out_rdata
);

	logic host_go;
	logic host_wr;
	mem_sel_t host_sel_q;

	// host is locked out while the engine runs
	assign host_go = host_en && !busy;
	assign host_wr = host_we && !busy;

	sp_ram #(.depth(param_depth), .width(data_w)) u_param (
		.clk(clk), .cs(busy ? param_cs : host_go && host_sel == sel_param), .we(host_wr),
		.addr(busy ? param_addr : host_addr[$clog2(param_depth)-1:0]),
		.wdata(host_wdata[data_w-1:0]), .rdata(param_rdata)
	);

	sp_ram #(.depth(bias_depth), .width(data_w)) u_bias (
		.clk(clk), .cs(busy ? bias_cs : host_go && host_sel == sel_bias), .we(host_wr),
		.addr(busy ? bias_addr : host_addr[$clog2(bias_depth)-1:0]),
		.wdata(host_wdata[data_w-1:0]), .rdata(bias_rdata)
	);

	sp_ram #(.depth(wt_depth), .width(code_w)) u_weight (
		.clk(clk), .cs(busy ? wt_cs : host_go && host_sel == sel_weight), .we(host_wr),
		.addr(busy ? wt_addr : host_addr[$clog2(wt_depth)-1:0]),
		.wdata(host_wdata), .rdata(wt_rdata)
	);

	sp_ram #(.depth(in_depth), .width(data_w)) u_input (
		.clk(clk), .cs(busy ? in_cs : host_go && host_sel == sel_input), .we(host_wr),
		.addr(busy ? in_addr : host_addr[$clog2(in_depth)-1:0]),
		.wdata(host_wdata[data_w-1:0]), .rdata(in_rdata)
	);

	// the only buffer the engine writes
	sp_ram #(.depth(out_depth), .width(data_w)) u_output (
		.clk(clk), .cs(busy ? out_cs : host_go && host_sel == sel_output),
		.we(busy ? out_we : host_we),
		.addr(busy ? out_addr : host_addr[$clog2(out_depth)-1:0]),
		.wdata(busy ? out_wdata : host_wdata[data_w-1:0]), .rdata(out_rdata)
	);

	always_ff @(posedge clk) begin
		if (host_go) begin
			host_sel_q <= host_sel;
		end
	end

	// steer read data back with the select of the previous cycle
	always_comb begin
		case (host_sel_q)
			sel_param: host_rdata = code_w'(param_rdata);
			sel_bias: host_rdata = code_w'(bias_rdata);
			sel_weight: host_rdata = wt_rdata;
			sel_input: host_rdata = code_w'(in_rdata);
			sel_output: host_rdata = code_w'(out_rdata);
			default: host_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/sp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sp_ram #(
	parameter int depth = 16,
	parameter int width = 16
) (
	input logic clk,
	input logic cs,
	input logic we,
	input logic [$clog2(depth)-1:0] addr,
	input logic [width-1:0] wdata,
	output logic [width-1:0] rdata
);

	logic [width-1:0] mem [depth];

	// read data only moves on a read cycle, so it holds between accesses
	always_ff @(posedge clk) begin
		if (cs) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

	// word widths
	localparam int data_w = 16;
	localparam int code_w = 18;
	localparam int lanes = 9;
	localparam int addr_w = 10;

	// buffer depths in words
	localparam int in_depth = 1024;
	localparam int out_depth = 512;
	localparam int wt_depth = 64;
	localparam int bias_depth = 16;
	localparam int param_depth = 4;

	// requantize shift and int8 saturation value
	localparam int shift_q = 5;
	localparam int sat_max = 127;

	typedef enum logic [2:0] {
		sel_param,
		sel_bias,
		sel_weight,
		sel_input,
		sel_output
	} mem_sel_t;

	typedef enum logic [2:0] {
		st_idle,
		st_ld_param,
		st_ld_bias,
		st_ld_wt,
		st_ld_in,
		st_calc,
		st_store,
		st_fin
	} ctrl_state_t;

	// acc_single is a kernel whose only group is both first and last
	typedef enum logic [1:0] {
		acc_first,
		acc_mid,
		acc_last,
		acc_single
	} acc_mode_t;

endpackage

`default_nettype wire
